/* verilog/tpuPkg.sv */
// Instruction type, APB register offsets and bank ring types for the instruction buffer
package tpuPkg;

	////////////////////
	// Instruction word

	parameter int instrWidth = 32;                  // Bits per instruction
	typedef logic [instrWidth-1:0] instrT;           // Opaque to the buffer

	////////////////////
	// Bank ring

	parameter int numBanks = 2;                      // Ping and pong

	// Pointer into the ring and occupancy count
	typedef logic [$clog2(numBanks)-1:0] bankPtrT;
	typedef logic [$clog2(numBanks + 1)-1:0] bankCountT;

	////////////////////
	// Host register map

	localparam logic [31:0] regInstr  = 32'h0000_0000;   // Push one word
	localparam logic [31:0] regCommit = 32'h0000_0004;   // Close staging bank
	localparam logic [31:0] regStatus = 32'h0000_0008;   // Flags and counts

	// STATUS layout
	//   0      empty
	//   1      full
	//   3:2    ready banks
	//   31:16  staged words

endpackage

/* verilog/ringBuffCtrl.sv */
// Ring buffer controller with write/read bank pointers and occupancy flags
`timescale 1ns/1ps

module ringBuffCtrl (
	input  logic              clock,
	input  logic              reset,
	input  logic              writeEnd,    // Staging bank committed
	input  logic              readEnd,     // Issuing bank released
	output tpuPkg::bankPtrT   writePtr,
	output tpuPkg::bankPtrT   readPtr,
	output logic              full,
	output logic              empty,
	output tpuPkg::bankCountT count
);

	localparam tpuPkg::bankPtrT lastPtr = tpuPkg::bankPtrT'(tpuPkg::numBanks - 1);

	logic doWrite;
	logic doRead;

	// Never overrun in either direction
	assign doWrite = writeEnd & ~full;
	assign doRead  = readEnd & ~empty;

	assign full  = (count == tpuPkg::bankCountT'(tpuPkg::numBanks));
	assign empty = (count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
		end else if (doWrite) begin
			writePtr <= (writePtr == lastPtr) ? '0 : writePtr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			readPtr <= '0;
		end else if (doRead) begin
			readPtr <= (readPtr == lastPtr) ? '0 : readPtr + 1'b1;
		end
	end

	// Both ends in one cycle leave the occupancy alone
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({doWrite, doRead})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* verilog/instrMem.sv */
// Double-banked instruction store with staging counter, bank lengths and registered read port
`timescale 1ns/1ps

module instrMem #(
	parameter int  imemSize   = 64,
	localparam int addrWidth  = $clog2(imemSize),
	localparam int countWidth = $clog2(imemSize + 1)
) (
	input  logic                  clock,
	input  logic                  reset,

	// Host side
	input  logic                  storeReq,
	input  tpuPkg::instrT         storeInstr,
	input  logic                  commitReq,
	output logic                  storeOk,       // Store would be accepted
	output logic                  commitOk,      // Commit would be accepted

	// Fetch side
	input  logic                  loadReq,
	input  logic [addrWidth-1:0]  loadAddr,
	input  logic                  loadEnd,       // Last word of read bank taken
	output tpuPkg::instrT         loadInstr,
	output logic [countWidth-1:0] loadLength,

	// Status
	output logic                  empty,
	output logic                  full,
	output tpuPkg::bankCountT     readyCount,
	output logic [15:0]           storeCount
);

	////////////////////
	// Storage

	tpuPkg::instrT         bankMem [tpuPkg::numBanks][imemSize];
	logic [countWidth-1:0] bankLength [tpuPkg::numBanks];   // Set at commit

	logic [countWidth-1:0] storeAddr;    // Next free slot in staging bank
	tpuPkg::bankPtrT       writePtr;
	tpuPkg::bankPtrT       readPtr;
	logic                  storeWe;
	logic                  commitWe;

	////////////////////
	// Acceptance

	// A full ring means the staging bank is still queued or issuing
	assign storeOk  = ~full & (storeAddr != countWidth'(imemSize));
	assign commitOk = ~full & (storeAddr != '0);   // No empty programs

	assign storeWe  = storeReq & storeOk;
	assign commitWe = commitReq & commitOk;

	assign storeCount = 16'(storeAddr);

	// Staging counter restarts for the next bank
	always_ff @(posedge clock) begin
		if (reset) begin
			storeAddr <= '0;
		end else if (commitWe) begin
			storeAddr <= '0;
		end else if (storeWe) begin
			storeAddr <= storeAddr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (storeWe) begin
			bankMem[writePtr][storeAddr[addrWidth-1:0]] <= storeInstr;
		end
	end

	// Program length follows the bank it was committed into
	always_ff @(posedge clock) begin
		if (commitWe) begin
			bankLength[writePtr] <= storeAddr;
		end
	end

	////////////////////
	// Read port

	always_ff @(posedge clock) begin
		if (loadReq) begin
			loadInstr <= bankMem[readPtr][loadAddr];   // One cycle latency
		end
	end

	assign loadLength = bankLength[readPtr];

	// Bank selection
	ringBuffCtrl ringBuffCtrl_i (
		.clock    (clock),
		.reset    (reset),
		.writeEnd (commitWe),
		.readEnd  (loadEnd),
		.writePtr (writePtr),
		.readPtr  (readPtr),
		.full     (full),
		.empty    (empty),
		.count    (readyCount)
	);

endmodule

/* verilog/apbLoader.sv */
// APB slave decoding instruction push, commit and status registers
`timescale 1ns/1ps

module apbLoader (
	input  logic              clock,
	input  logic              reset,

	// APB slave
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,

	// Requests to the store
	output logic              storeReq,
	output tpuPkg::instrT     storeInstr,
	output logic              commitReq,

	// Answers and status from the store
	input  logic              storeOk,
	input  logic              commitOk,
	input  logic              empty,
	input  logic              full,
	input  tpuPkg::bankCountT readyCount,
	input  logic [15:0]       storeCount
);

	logic        setupPhase;
	logic        accessPhase;
	logic        hitInstr;
	logic        hitCommit;
	logic        hitStatus;
	logic        mapped;
	logic        refused;       // Store or commit turned down
	logic [31:0] statusWord;

	assign setupPhase  = psel & ~penable;
	assign accessPhase = psel & penable;

	// Address decode
	assign hitInstr  = (paddr == tpuPkg::regInstr);
	assign hitCommit = (paddr == tpuPkg::regCommit);
	assign hitStatus = (paddr == tpuPkg::regStatus);
	assign mapped    = hitInstr | hitCommit | hitStatus;

	// Single pulse in the access cycle
	assign storeReq   = accessPhase & pwrite & hitInstr;
	assign commitReq  = accessPhase & pwrite & hitCommit;
	assign storeInstr = tpuPkg::instrT'(pwdata);

	assign refused = (storeReq & ~storeOk) | (commitReq & ~commitOk);

	assign pready  = 1'b1;   // No wait states
	assign pslverr = accessPhase & (~mapped | (pwrite & hitStatus) | refused);

	assign statusWord = {storeCount, 12'd0, readyCount, full, empty};

	// Read data is sampled in the setup cycle and held through access
	always_ff @(posedge clock) begin
		if (reset) begin
			prdata <= '0;
		end else if (setupPhase) begin
			prdata <= (~pwrite & hitStatus) ? statusWord : '0;
		end
	end

endmodule

/* verilog/instrFetch.sv */
// Fetch FSM walking a committed bank and issuing words on a valid/ready stream
`timescale 1ns/1ps

module instrFetch #(
	parameter int  imemSize   = 64,
	localparam int addrWidth  = $clog2(imemSize),
	localparam int countWidth = $clog2(imemSize + 1)
) (
	input  logic                  clock,
	input  logic                  reset,

	// From the store
	input  logic                  empty,
	input  logic [countWidth-1:0] loadLength,
	input  tpuPkg::instrT         loadInstr,
	output logic                  loadReq,
	output logic [addrWidth-1:0]  loadAddr,
	output logic                  loadEnd,     // Bank done, release it

	// Issue stream to the core
	output logic                  issueValid,
	output tpuPkg::instrT         issueInstr,
	input  logic                  issueReady
);

	typedef enum logic [1:0] {
		stateIdle,   // Waiting for a ready bank
		stateRead,   // Read data arrives
		stateHold    // Word offered to the core
	} fetchStateT;

	fetchStateT state;
	logic       accepted;
	logic       lastWord;

	assign accepted = (state == stateHold) & issueReady;
	assign lastWord = ((countWidth'(loadAddr) + 1'b1) == loadLength);

	assign loadReq    = (state == stateIdle) & ~empty;
	assign loadEnd    = accepted & lastWord;
	assign issueValid = (state == stateHold);

	////////////////////
	// Control

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= stateIdle;
		end else begin
			case (state)
				stateIdle: begin
					if (~empty) begin
						state <= stateRead;
					end
				end
				stateRead: begin
					state <= stateHold;
				end
				stateHold: begin
					if (issueReady) begin
						state <= stateIdle;   // Next word starts here
					end
				end
				default: begin
					state <= stateIdle;
				end
			endcase
		end
	end

	// Word address within the bank
	always_ff @(posedge clock) begin
		if (reset) begin
			loadAddr <= '0;
		end else if (accepted) begin
			loadAddr <= lastWord ? '0 : loadAddr + 1'b1;
		end
	end

	////////////////////
	// Issue register

	always_ff @(posedge clock) begin
		if (state == stateRead) begin
			issueInstr <= loadInstr;   // Stable until accepted
		end
	end

endmodule

/* verilog/instrBufferTop.sv */
// Top level of the instruction buffer joining APB loader, banked store and fetch unit
`timescale 1ns/1ps

module instrBufferTop #(
	parameter int  imemSize   = 64,
	localparam int addrWidth  = $clog2(imemSize),
	localparam int countWidth = $clog2(imemSize + 1)
) (
	input  logic          clock,
	input  logic          reset,

	// Host port
	input  logic          psel,
	input  logic          penable,
	input  logic          pwrite,
	input  logic [31:0]   paddr,
	input  logic [31:0]   pwdata,
	output logic [31:0]   prdata,
	output logic          pready,
	output logic          pslverr,

	// Issue stream
	output logic          issueValid,
	output tpuPkg::instrT issueInstr,
	input  logic          issueReady
);

	// Loader to store
	logic                  storeReq;
	tpuPkg::instrT         storeInstr;
	logic                  commitReq;
	logic                  storeOk;
	logic                  commitOk;
	logic                  full;
	tpuPkg::bankCountT     readyCount;
	logic [15:0]           storeCount;

	// Store to fetch
	logic                  empty;
	logic                  loadReq;
	logic [addrWidth-1:0]  loadAddr;
	logic                  loadEnd;
	tpuPkg::instrT         loadInstr;
	logic [countWidth-1:0] loadLength;

	apbLoader apbLoader_i (
		.clock      (clock),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.storeReq   (storeReq),
		.storeInstr (storeInstr),
		.commitReq  (commitReq),
		.storeOk    (storeOk),
		.commitOk   (commitOk),
		.empty      (empty),
		.full       (full),
		.readyCount (readyCount),
		.storeCount (storeCount)
	);

	instrMem #(
		.imemSize (imemSize)
	) instrMem_i (
		.clock      (clock),
		.reset      (reset),
		.storeReq   (storeReq),
		.storeInstr (storeInstr),
		.commitReq  (commitReq),
		.storeOk    (storeOk),
		.commitOk   (commitOk),
		.loadReq    (loadReq),
		.loadAddr   (loadAddr),
		.loadEnd    (loadEnd),
		.loadInstr  (loadInstr),
		.loadLength (loadLength),
		.empty      (empty),
		.full       (full),
		.readyCount (readyCount),
		.storeCount (storeCount)
	);

	instrFetch #(
		.imemSize (imemSize)
	) instrFetch_i (
		.clock      (clock),
		.reset      (reset),
		.empty      (empty),
		.loadLength (loadLength),
		.loadInstr  (loadInstr),
		.loadReq    (loadReq),
		.loadAddr   (loadAddr),
		.loadEnd    (loadEnd),
		.issueValid (issueValid),
		.issueInstr (issueInstr),
		.issueReady (issueReady)
	);

endmodule

/* testbench/instrBufferTb.sv */
// Testbench for the instruction buffer with APB tasks, reference model, issue checker and watchdog
`timescale 1ns/1ps

module instrBufferTb;

	localparam int imemSize         = 8;
	localparam int plannedTransfers = 38;
	localparam int plannedWords     = 20;
	localparam int timeoutCycles    = (plannedTransfers + plannedWords) * 20;

	logic          clock;
	logic          reset;
	logic          psel;
	logic          penable;
	logic          pwrite;
	logic [31:0]   paddr;
	logic [31:0]   pwdata;
	logic [31:0]   prdata;
	logic          pready;
	logic          pslverr;
	logic          issueValid;
	tpuPkg::instrT issueInstr;
	logic          issueReady;

	int            errorCount = 0;
	int            checkCount = 0;
	int            readyMode  = 0;   // 0 low, 1 high, 2 random

	// Reference model state
	logic [31:0]   stageQueue[$];    // Words in the staging bank
	logic [31:0]   expQueue[$];      // Committed words still to issue
	int            lenQueue[$];      // Words left per committed program

	instrBufferTop #(
		.imemSize (imemSize)
	) instrBufferTop_i (
		.clock      (clock),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.issueValid (issueValid),
		.issueInstr (issueInstr),
		.issueReady (issueReady)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	////////////////////
	// Reference model

	function automatic logic [31:0] expectedWord();
		return expQueue[0];
	endfunction

	function automatic logic expectedErr(input logic [31:0] addr, input logic write);
		if (addr == tpuPkg::regInstr)
			return write & (lenQueue.size() == tpuPkg::numBanks || stageQueue.size() == imemSize);
		if (addr == tpuPkg::regCommit)
			return write & (stageQueue.size() == 0 || lenQueue.size() == tpuPkg::numBanks);
		if (addr == tpuPkg::regStatus)
			return write;
		return 1'b1;   // Unmapped
	endfunction

	function automatic logic [31:0] modelStatus();
		int banks;
		banks = lenQueue.size();
		return {16'(stageQueue.size()), 12'd0, 2'(banks),
			banks == tpuPkg::numBanks, banks == 0};
	endfunction

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	////////////////////
	// APB host

	task automatic apbAccess(input logic [31:0] addr, input logic write,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(posedge clock);
		#5;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(posedge clock);
		#5;
		penable = 1'b1;
		@(negedge clock);   // Mid access cycle
		rdata = prdata;
		err   = pslverr;
		checkValue("pready", 32'(pready), 32'd1);   // No wait states on the host port
		@(posedge clock);
		#5;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic writeReg(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		logic        expErr;
		expErr = expectedErr(addr, 1'b1);
		apbAccess(addr, 1'b1, data, rdata, err);
		checkValue($sformatf("pslverr of write to %h", addr), 32'(err), 32'(expErr));
		if (!expErr && addr == tpuPkg::regInstr) begin
			stageQueue.push_back(data);
		end else if (!expErr && addr == tpuPkg::regCommit) begin
			lenQueue.push_back(stageQueue.size());
			foreach (stageQueue[i]) expQueue.push_back(stageQueue[i]);
			stageQueue.delete();
		end
	endtask

	task automatic readReg(input logic [31:0] addr);
		logic [31:0] rdata;
		logic        err;
		logic        expErr;
		expErr = expectedErr(addr, 1'b0);
		apbAccess(addr, 1'b0, 32'd0, rdata, err);
		checkValue($sformatf("pslverr of read from %h", addr), 32'(err), 32'(expErr));
		if (addr == tpuPkg::regStatus) checkValue("STATUS", rdata, modelStatus());
	endtask

	task automatic loadProgram(input int words);
		for (int i = 0; i < words; i++) writeReg(tpuPkg::regInstr, $urandom());
		writeReg(tpuPkg::regCommit, 32'd0);
	endtask

	// Let every committed word issue, then let the release settle
	task automatic waitDrained();
		while (expQueue.size() != 0) @(posedge clock);
		repeat (4) @(posedge clock);
		@(negedge clock);
		checkValue("issueValid when idle", 32'(issueValid), 32'd0);
	endtask

	////////////////////
	// Issue side

	always @(posedge clock) begin
		#5;
		case (readyMode)
			0:       issueReady = 1'b0;
			1:       issueReady = 1'b1;
			default: issueReady = 1'($urandom % 2);
		endcase
	end

	// Handshake is stable here and the word is taken on the next edge
	always @(negedge clock) begin
		if (!reset && issueValid && issueReady) begin
			if (expQueue.size() == 0) begin
				errorCount++;
				$display("Error at %0t ns: word %h issued with no program pending", $time,
					issueInstr);
			end else begin
				checkValue("issued word", issueInstr, expectedWord());
				void'(expQueue.pop_front());
				lenQueue[0] = lenQueue[0] - 1;
				if (lenQueue[0] == 0) void'(lenQueue.pop_front());
			end
		end
	end

	initial begin
		#(timeoutCycles * 100);
		$display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
		$display("TB FAILED");
		$finish;
	end

	////////////////////
	// Tests

	initial begin
		void'($urandom(85834));
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		issueReady = 1'b0;
		repeat (8) @(posedge clock);
		#5;
		reset = 1'b0;

		// Reset state
		@(negedge clock);
		checkValue("issueValid after reset", 32'(issueValid), 32'd0);
		readReg(tpuPkg::regStatus);

		// Single program under random back-pressure
		readyMode = 2;
		loadProgram(5);
		waitDrained();
		readReg(tpuPkg::regStatus);

		// Both banks queued while the core stalls
		readyMode = 0;
		loadProgram(3);
		loadProgram(4);
		readReg(tpuPkg::regStatus);
		writeReg(tpuPkg::regInstr, $urandom());   // Ring is full
		readyMode = 2;
		waitDrained();
		readReg(tpuPkg::regStatus);

		// Ninth word into an 8-word bank, then an empty commit
		for (int i = 0; i < imemSize + 1; i++) writeReg(tpuPkg::regInstr, $urandom());
		writeReg(tpuPkg::regCommit, 32'd0);
		waitDrained();
		writeReg(tpuPkg::regCommit, 32'd0);
		repeat (10) @(posedge clock);
		readReg(tpuPkg::regStatus);

		// Unmapped address and STATUS write leave staging alone
		writeReg(tpuPkg::regInstr, $urandom());
		writeReg(tpuPkg::regInstr, $urandom());
		writeReg(32'h0000_0010, $urandom());
		readReg(32'h0000_0010);
		writeReg(tpuPkg::regStatus, $urandom());
		readReg(tpuPkg::regStatus);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* instrBuffer.f */
verilog/tpuPkg.sv
verilog/ringBuffCtrl.sv
verilog/instrMem.sv
verilog/apbLoader.sv
verilog/instrFetch.sv
verilog/instrBufferTop.sv
testbench/instrBufferTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the instruction buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module instrBufferTb -f instrBuffer.f -o instrBufferSim

./obj_dir/instrBufferSim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
